//--- design/bus_memory.sv
//////////////////////////////////////////////////////////////////////
// Serves one request at a time in FIFO order. Read len must be nonzero.
// Contents are not reset and addresses wrap at MEM_BEATS.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dcache_config.svh"

module bus_memory (
	input  logic                 clk,
	input  logic                 rst_n,
	input  dcache_pkg::bus_req_t bus_req,
	output logic                 credit,
	output dcache_pkg::bus_rsp_t bus_rsp
);

	import dcache_pkg::*;

	localparam int PTR_W = $clog2(`BUS_CREDITS);
	localparam int CNT_FIFO_W = $clog2(`BUS_CREDITS + 1);
	localparam int MEM_AW = $clog2(`MEM_BEATS);
	localparam int CNT_W = 4;

	bus_req_t              fifo_mem [`BUS_CREDITS];
	logic [PTR_W-1:0]      wr_ptr_q;
	logic [PTR_W-1:0]      rd_ptr_q;
	logic [CNT_FIFO_W-1:0] count_q;
	bus_req_t              fifo_head;
	logic                  push;
	logic                  pop;

	logic [63:0]       mem [`MEM_BEATS];
	mem_state_e        state_q;
	logic [CNT_W-1:0]  cnt_q;
	logic [MEM_AW-1:0] beat_ptr_q;
	logic [63:0]       head_data_q;
	logic [7:0]        head_mask_q;
	logic              write_retire;

	//////////////////////////////////////////////////////////////////////
	// Request FIFO.
	//////////////////////////////////////////////////////////////////////

	// Credits match the depth, so a push never finds it full.
	assign push = bus_req.valid;
	assign pop = (state_q == MEM_IDLE) && (count_q != '0);
	assign fifo_head = fifo_mem[rd_ptr_q];
	assign credit = pop;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + PTR_W'(1);
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + PTR_W'(1);
			end
			count_q <= count_q + CNT_FIFO_W'(push) - CNT_FIFO_W'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr_q] <= bus_req;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Service FSM.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= MEM_IDLE;
			cnt_q <= '0;
		end else begin
			unique case (state_q)
				MEM_IDLE: begin
					if (pop && (fifo_head.mode == BUS_WRITE)) begin
						state_q <= MEM_WRITE;
						cnt_q <= CNT_W'(`MEM_WRITE_CYCLES - 1);
					end else if (pop) begin
						state_q <= MEM_BURST;
						cnt_q <= fifo_head.len - CNT_W'(1);
					end
				end
				MEM_WRITE, MEM_BURST: begin
					if (cnt_q == '0) begin
						state_q <= MEM_IDLE;
					end else begin
						cnt_q <= cnt_q - CNT_W'(1);
					end
				end
				default: state_q <= MEM_IDLE;
			endcase
		end
	end

	// Mask lands on the last cycle of the write.
	assign write_retire = (state_q == MEM_WRITE) && (cnt_q == '0);

	always_ff @(posedge clk) begin
		if (pop) begin
			head_data_q <= fifo_head.data;
			head_mask_q <= fifo_head.mask;
			beat_ptr_q <= fifo_head.addr[3 +: MEM_AW];
		end else if (state_q == MEM_BURST) begin
			beat_ptr_q <= beat_ptr_q + MEM_AW'(1);
		end
		if (write_retire) begin
			for (int b = 0; b < 8; b++) begin
				if (head_mask_q[b]) begin
					mem[beat_ptr_q][b*8 +: 8] <= head_data_q[b*8 +: 8];
				end
			end
		end
	end

	// One beat per cycle while bursting.
	assign bus_rsp.valid = (state_q == MEM_BURST);
	assign bus_rsp.data = mem[beat_ptr_q];

endmodule

//--- design/dcache_bus_master.sv
//////////////////////////////////////////////////////////////////////
// Every outbound request is a single cycle, so one credit per request.
// Writes are word sized only and never allocate a line.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_bus_master (
	input  logic                         clk,
	input  logic                         rst_n,
	input  dcache_pkg::core_req_t        core,
	input  logic                         hit,
	output logic                         rw_wait,
	output logic                         core_we,
	output dcache_pkg::bus_req_t         bus_req,
	input  logic                         credit,
	input  dcache_pkg::bus_rsp_t         bus_rsp,
	output logic                         fill_start,
	output logic                         fill_we,
	output logic                         fill_done,
	output logic [`DC_IDX_W-1:0]         fill_idx,
	output logic [$clog2(`DC_BEATS)-1:0] fill_beat,
	output logic [`DC_TAG_W-1:0]         fill_tag,
	output logic [63:0]                  fill_data
);

	import dcache_pkg::*;

	localparam int CRED_W = $clog2(`BUS_CREDITS + 1);
	localparam int BEAT_W = $clog2(`DC_BEATS);
	localparam int OFS_W = 32 - `DC_TAG_W - `DC_IDX_W;

	logic [CRED_W-1:0]    credits_q;
	logic                 credit_avail;
	fill_state_e          state_q;
	logic [BEAT_W-1:0]    beat_q;
	logic [`DC_IDX_W-1:0] fill_idx_q;
	logic [`DC_TAG_W-1:0] fill_tag_q;
	logic                 start_read;
	logic                 start_write;

	//////////////////////////////////////////////////////////////////////
	// Credits.
	//////////////////////////////////////////////////////////////////////

	assign credit_avail = (credits_q != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits_q <= CRED_W'(`BUS_CREDITS);
		end else begin
			credits_q <= credits_q + CRED_W'(credit) - CRED_W'(bus_req.valid);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request issue.
	//////////////////////////////////////////////////////////////////////

	// A miss can only start a fill when none is pending.
	assign start_read = core.rd && !hit && (state_q == FILL_IDLE) && credit_avail;
	assign start_write = core.wr && credit_avail;

	assign rw_wait = (core.rd && !hit) || (core.wr && !credit_avail);
	assign core_we = start_write && hit;

	always_comb begin
		bus_req = '0;
		if (start_read) begin
			bus_req.valid = 1'b1;
			bus_req.mode = BUS_READ;
			bus_req.addr = {core.addr[31:OFS_W], {OFS_W{1'b0}}};
			bus_req.len = 4'(`DC_BEATS);
		end else if (start_write) begin
			bus_req.valid = 1'b1;
			bus_req.mode = BUS_WRITE;
			bus_req.addr = {core.addr[31:3], 3'b000};
			bus_req.len = 4'd1;
			// Same word in both halves, the mask selects the lane.
			bus_req.data = {core.wr_data, core.wr_data};
			bus_req.mask = core.addr[2] ? 8'hF0 : 8'h0F;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fill tracking.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= FILL_IDLE;
			beat_q <= '0;
		end else begin
			unique case (state_q)
				FILL_IDLE: begin
					if (start_read) begin
						state_q <= FILL_WAIT;
						beat_q <= '0;
					end
				end
				FILL_WAIT: begin
					if (bus_rsp.valid) begin
						beat_q <= beat_q + BEAT_W'(1);
						if (fill_done) begin
							state_q <= FILL_IDLE;
						end
					end
				end
				default: state_q <= FILL_IDLE;
			endcase
		end
	end

	// Line being filled.
	always_ff @(posedge clk) begin
		if (start_read) begin
			fill_idx_q <= core.addr[OFS_W +: `DC_IDX_W];
			fill_tag_q <= core.addr[31 -: `DC_TAG_W];
		end
	end

	assign fill_start = start_read;
	assign fill_we = (state_q == FILL_WAIT) && bus_rsp.valid;
	assign fill_done = fill_we && (beat_q == BEAT_W'(`DC_BEATS - 1));
	// The issue cycle needs the index before it is registered.
	assign fill_idx = (state_q == FILL_IDLE) ? core.addr[OFS_W +: `DC_IDX_W] : fill_idx_q;
	assign fill_beat = beat_q;
	assign fill_tag = fill_tag_q;
	assign fill_data = bus_rsp.data;

endmodule

//--- design/dcache_config.svh
//////////////////////////////////////////////////////////////////////
// Geometry assumes 32-bit addresses. DC_BEATS, BUS_CREDITS and
// MEM_BEATS must be powers of two, since pointers wrap naturally.
//////////////////////////////////////////////////////////////////////
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry: 16 lines of 64 bytes.
`define DC_LINES 16
`define DC_TAG_W 22
`define DC_IDX_W 4
`define DC_BEATS 8

// Outstanding request slots, also the memory FIFO depth.
`define BUS_CREDITS 4

// Memory size in 64-bit beats (8 KB). Addresses wrap above this.
`define MEM_BEATS 1024

// Cycles a write keeps the memory busy after its pop.
`define MEM_WRITE_CYCLES 2

`endif

//--- design/dcache_data_store.sv
//////////////////////////////////////////////////////////////////////
// Reads are combinational. Fill and core write never target one line
// in the same cycle, since the core stalls for the whole fill.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_data_store (
	input  logic                         clk,
	input  logic [31:0]                  addr,
	input  logic                         core_we,
	input  logic [31:0]                  wr_data,
	input  logic                         fill_we,
	input  logic [`DC_IDX_W-1:0]         fill_idx,
	input  logic [$clog2(`DC_BEATS)-1:0] fill_beat,
	input  logic [63:0]                  fill_data,
	output logic [31:0]                  rd_data
);

	localparam int BEAT_W = $clog2(`DC_BEATS);
	localparam int WORD_AW = `DC_IDX_W + BEAT_W;
	localparam int OFS_W = BEAT_W + 3;

	// Each 64-bit beat is split over the two banks.
	logic [31:0] bank_hi [`DC_LINES * `DC_BEATS];
	logic [31:0] bank_lo [`DC_LINES * `DC_BEATS];

	logic [WORD_AW-1:0] core_word;
	logic [WORD_AW-1:0] fill_word;

	// Word address is {line index, beat}.
	assign core_word = {addr[OFS_W +: `DC_IDX_W], addr[3 +: BEAT_W]};
	assign fill_word = {fill_idx, fill_beat};

	// Address bit 2 picks the upper word of the beat.
	assign rd_data = addr[2] ? bank_hi[core_word] : bank_lo[core_word];

	//////////////////////////////////////////////////////////////////////
	// Write ports.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (fill_we) begin
			bank_hi[fill_word] <= fill_data[63:32];
			bank_lo[fill_word] <= fill_data[31:0];
		end else if (core_we) begin
			// Only the addressed word changes.
			if (addr[2]) begin
				bank_hi[core_word] <= wr_data;
			end else begin
				bank_lo[core_word] <= wr_data;
			end
		end
	end

endmodule

//--- design/dcache_pkg.sv
//////////////////////////////////////////////////////////////////////
// Single bus master only, so requests carry no device routing fields.
//////////////////////////////////////////////////////////////////////
package dcache_pkg;

	typedef enum logic {
		BUS_READ  = 1'b0,
		BUS_WRITE = 1'b1
	} bus_mode_e;

	// Core side request, held stable while rw_wait is high.
	typedef struct packed {
		logic [31:0] addr;
		logic        rd;
		logic        wr;
		logic [31:0] wr_data;
	} core_req_t;

	// Outbound bus request, accepted in the cycle valid is set.
	typedef struct packed {
		logic        valid;
		bus_mode_e   mode;
		logic [31:0] addr;
		logic [3:0]  len;
		logic [63:0] data;
		logic [7:0]  mask;
	} bus_req_t;

	// Inbound read beat.
	typedef struct packed {
		logic        valid;
		logic [63:0] data;
	} bus_rsp_t;

	typedef enum logic {
		FILL_IDLE,
		FILL_WAIT
	} fill_state_e;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_WRITE,
		MEM_BURST
	} mem_state_e;

endpackage

//--- design/dcache_subsystem_top.sv
//////////////////////////////////////////////////////////////////////
// Core holds its request until rw_wait is low at a rising edge.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module dcache_subsystem_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  dcache_pkg::core_req_t core,
	output logic                  rw_wait,
	output logic [31:0]           rd_data
);

	import dcache_pkg::*;

	bus_req_t    bus_req;
	bus_rsp_t    bus_rsp;
	logic        credit;
	logic        hit;
	logic        core_we;
	logic        fill_start;
	logic        fill_we;
	logic        fill_done;
	logic [3:0]  fill_idx;
	logic [2:0]  fill_beat;
	logic [21:0] fill_tag;
	logic [63:0] fill_data;

	// Cache arrays.
	dcache_tag_store i_tag_store (
		.clk(clk), .rst_n(rst_n), .lookup_addr(core.addr),
		.fill_start(fill_start), .fill_done(fill_done),
		.fill_idx(fill_idx), .fill_tag(fill_tag), .hit(hit)
	);

	dcache_data_store i_data_store (
		.clk(clk), .addr(core.addr), .core_we(core_we), .wr_data(core.wr_data),
		.fill_we(fill_we), .fill_idx(fill_idx), .fill_beat(fill_beat),
		.fill_data(fill_data), .rd_data(rd_data)
	);

	// Miss handling and bus requests.
	dcache_bus_master i_bus_master (
		.clk(clk), .rst_n(rst_n), .core(core), .hit(hit),
		.rw_wait(rw_wait), .core_we(core_we), .bus_req(bus_req),
		.credit(credit), .bus_rsp(bus_rsp), .fill_start(fill_start),
		.fill_we(fill_we), .fill_done(fill_done), .fill_idx(fill_idx),
		.fill_beat(fill_beat), .fill_tag(fill_tag), .fill_data(fill_data)
	);

	// Backing memory on the bus.
	bus_memory i_memory (
		.clk(clk), .rst_n(rst_n), .bus_req(bus_req),
		.credit(credit), .bus_rsp(bus_rsp)
	);

endmodule

//--- design/dcache_tag_store.sv
//////////////////////////////////////////////////////////////////////
// Lookup is combinational. Only one fill is ever in flight.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_tag_store (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0]          lookup_addr,
	input  logic                 fill_start,
	input  logic                 fill_done,
	input  logic [`DC_IDX_W-1:0] fill_idx,
	input  logic [`DC_TAG_W-1:0] fill_tag,
	output logic                 hit
);

	// Bits below the index select a byte within the line.
	localparam int OFS_W = 32 - `DC_TAG_W - `DC_IDX_W;

	logic [`DC_LINES-1:0] valid_q;
	logic [`DC_TAG_W-1:0] tags [`DC_LINES];

	logic [`DC_IDX_W-1:0] lookup_idx;
	logic [`DC_TAG_W-1:0] lookup_tag;

	assign lookup_idx = lookup_addr[OFS_W +: `DC_IDX_W];
	assign lookup_tag = lookup_addr[31 -: `DC_TAG_W];

	assign hit = valid_q[lookup_idx] && (tags[lookup_idx] == lookup_tag);

	//////////////////////////////////////////////////////////////////////
	// Valid bits.
	//////////////////////////////////////////////////////////////////////

	// A line goes invalid when its fill starts and valid again
	// on the edge that stores the last beat.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (fill_done) begin
			valid_q[fill_idx] <= 1'b1;
		end else if (fill_start) begin
			valid_q[fill_idx] <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tags.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (fill_done) begin
			tags[fill_idx] <= fill_tag;
		end
	end

endmodule

//--- list.f
+incdir+design
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_bus_master.sv
design/bus_memory.sv
design/dcache_subsystem_top.sv
sim/tb_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_dcache -o tb_dcache > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

./obj_dir/tb_dcache > "$SIM_LOG" 2>&1 ; cat "$SIM_LOG"

grep -q "All tests passed" "$SIM_LOG" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }

//--- sim/tb_dcache.sv
//////////////////////////////////////////////////////////////////////
// Checks only words written here, since memory contents are not reset.
// Test addresses stay below 8 KB so they never alias in the memory.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dcache_config.svh"

module tb_dcache;

	import dcache_pkg::*;

	// Worst request is a line read behind a full FIFO of writes.
	localparam int WORST_REQ = `BUS_CREDITS * (1 + `MEM_WRITE_CYCLES) + `DC_BEATS + 3;
	localparam int NUM_REQS = 52;
	localparam int TIMEOUT_CYCLES = 2 * (NUM_REQS * WORST_REQ + 10);

	logic        clk;
	logic        rst_n;
	core_req_t   core;
	logic        rw_wait;
	logic [31:0] rd_data;

	// Scoreboard of 32-bit words over the 8 KB memory.
	logic [31:0] sb_data [2048];
	logic        sb_valid [2048];
	int          seed;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;

	dcache_subsystem_top i_dut (
		.clk(clk), .rst_n(rst_n), .core(core), .rw_wait(rw_wait), .rd_data(rd_data)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Checks and core port tasks.
	//////////////////////////////////////////////////////////////////////

	task automatic expect_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond) else begin
			$display("Error: %s", what);
			test_errors++;
		end
	endtask

	// Called just after a rising edge. Returns after the completing edge.
	task automatic core_access(input logic [31:0] addr, input logic wr,
			input logic [31:0] wdata, output logic [31:0] data, output int stalls);
		stalls = 0;
		core.addr = addr;
		core.rd = !wr;
		core.wr = wr;
		core.wr_data = wdata;
		@(negedge clk);
		while (rw_wait) begin
			stalls++;
			@(negedge clk);
		end
		data = rd_data;
		@(posedge clk);
		#1;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
			output int stalls);
		logic [31:0] ignored_data;
		core_access(addr, 1'b1, wdata, ignored_data, stalls);
		sb_data[addr[12:2]] = wdata;
		sb_valid[addr[12:2]] = 1'b1;
	endtask

	task automatic read_check(input logic [31:0] addr, output int stalls);
		logic [31:0] data;
		core_access(addr, 1'b0, 32'h0, data, stalls);
		if (sb_valid[addr[12:2]]) begin
			expect_val("rd_data", data, sb_data[addr[12:2]]);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			$display("Test %0d %s: FAILED with %0d errors", tests_run, name, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
		core = '0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence.
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] data;
		logic [31:0] addrs [12];
		int          stalls;
		logic        stall_seen;
		clk = 1'b0;
		rst_n = 1'b0;
		core = '0;
		seed = 32'hef34;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 2048; i++) begin
			sb_valid[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Reset state. The random read stays on line index 0.
		@(negedge clk);
		expect_val("rw_wait", rw_wait, 32'h0);
		@(posedge clk);
		#1;
		a = $random(seed) & 32'h1c3c;
		core_access(a, 1'b0, 32'h0, data, stalls);
		expect_true(stalls > 0, "first read after reset did not stall");
		finish_test("reset state");

		// Writes miss without allocating, then the read fills the line.
		a = 32'h0000_0140;
		for (int i = 0; i < 4; i++) begin
			write_word(a + 32'(i * 12), $random(seed), stalls);
		end
		read_check(a, stalls);
		expect_true(stalls > 0, "read of an uncached line did not miss");
		for (int i = 1; i < 4; i++) begin
			read_check(a + 32'(i * 12), stalls);
			expect_true(stalls == 0, "read of a filled line did not hit");
		end
		finish_test("write then read through a miss");

		// Both words of one beat.
		a = 32'h0000_01c8;
		write_word(a, $random(seed), stalls);
		write_word(a + 32'h4, $random(seed), stalls);
		read_check(a, stalls);
		read_check(a + 32'h4, stalls);
		write_word(a, $random(seed), stalls);
		read_check(a + 32'h4, stalls);
		read_check(a, stalls);
		finish_test("word lanes");

		a = 32'h0000_02a4;
		write_word(a, $random(seed), stalls);
		read_check(a, stalls);
		write_word(a, $random(seed), stalls);
		read_check(a, stalls);
		expect_true(stalls == 0, "read after a write hit did not hit");
		read_check(a ^ 32'h400, stalls);
		expect_true(stalls > 0, "read with a new tag did not miss");
		read_check(a, stalls);
		expect_true(stalls > 0, "read of an evicted line did not miss");
		finish_test("write hit");

		a = 32'h0000_0310;
		b = a ^ 32'h800;
		write_word(a, $random(seed), stalls);
		write_word(b, $random(seed), stalls);
		for (int i = 0; i < 2; i++) begin
			read_check(a, stalls);
			expect_true(stalls > 0, "conflicting read of the first address did not miss");
			read_check(b, stalls);
			expect_true(stalls > 0, "conflicting read of the second address did not miss");
		end
		finish_test("conflict eviction");

		// Writes arrive faster than the memory retires them.
		stall_seen = 1'b0;
		for (int i = 0; i < 12; i++) begin
			addrs[i] = $random(seed) & 32'h1ffc;
			write_word(addrs[i], $random(seed), stalls);
			if (stalls > 0) begin
				stall_seen = 1'b1;
			end
		end
		expect_true(stall_seen, "back-to-back writes never ran out of credits");
		for (int i = 0; i < 12; i++) begin
			read_check(addrs[i], stalls);
		end
		finish_test("credit back-pressure");

		$display("Summary: %0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, errors);
		if (tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule
